// ==== logic/mapper_pkg.sv ====
`default_nettype none

package mapper_pkg;

    localparam int num_regions = 8;

    // register map
    localparam logic [4:0] reg_data_hi = 5'd0;
    localparam logic [4:0] reg_data_lo = 5'd1;
    localparam logic [4:0] reg_sys     = 5'd2;  // bit 0 cpu reset, bit 1 halt
    localparam logic [4:0] reg_snd     = 5'd3;  // latch towards the sound cpu
    localparam logic [4:0] reg_ipl     = 5'd4;
    localparam logic [4:0] reg_ctrl    = 5'd5;  // transfer opcode in [1:0]
    localparam logic [4:0] reg_rdaddr  = 5'd7;  // 7..9
    localparam logic [4:0] reg_wraddr  = 5'd10; // 10..12
    localparam logic [4:0] reg_dout_hi = 5'd13;
    localparam logic [4:0] reg_dout_lo = 5'd14;
    localparam logic [4:0] reg_region  = 5'd16; // size at even, base at odd index

    typedef enum logic [1:0] {
        op_none  = 2'b00,
        op_write = 2'b01,
        op_read  = 2'b10
    } xfer_op_t;

    typedef enum logic [1:0] {
        st_idle,
        st_request,
        st_access
    } xfer_state_t;

endpackage

`default_nettype wire

// ==== logic/xfer_if.sv ====
`timescale 1ns/100ps
`default_nettype none

interface xfer_if import mapper_pkg::*; ();

    logic        start;     // single cycle, only while not busy
    xfer_op_t    op;
    logic [23:1] rd_addr;
    logic [23:1] wr_addr;
    logic [15:0] wr_data;
    logic        busy;
    logic        done;      // single cycle
    logic [15:0] rd_data;   // valid with done

    modport regs (
        output start, op, rd_addr, wr_addr, wr_data,
        input  busy, done, rd_data
    );

    modport engine (
        input  start, op, rd_addr, wr_addr, wr_data,
        output busy, done, rd_data
    );

endinterface

`default_nettype wire

// ==== logic/mapper_regs.sv ====
`timescale 1ns/100ps
`default_nettype none

module mapper_regs import mapper_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    // main cpu
    input  logic [5:1] cpu_addr,
    input  logic [7:0] cpu_dout,
    input  logic       cpu_asn,
    input  logic [1:0] cpu_dsn,
    input  logic       cpu_rnw,
    input  logic       none,
    input  logic [2:0] cpu_fc,
    // mcu
    input  logic [4:0] mcu_addr,
    input  logic [7:0] mcu_dout,
    input  logic       mcu_wr,
    output logic [7:0] mcu_din,
    // sound cpu
    input  logic       sndmap_wr,
    input  logic [7:0] sndmap_din,
    input  logic       sndmap_rd,
    output logic [7:0] sndmap_dout,
    output logic       sndmap_pbf,
    output logic       snd_intn,
    input  logic       inta,
    output logic [7:0] regs [0:31],
    output logic       mcu_owns,
    xfer_if.regs       x
);

logic       cpu_wr_cond;
logic       cpu_wr_last;
logic       wr_en;
logic [4:0] wr_idx;
logic [7:0] wr_dat;
logic       rd_pend;    // transfer in flight is a read
logic [7:0] snd_latch;

// lower byte write to the mapper itself, never during an interrupt acknowledge
assign cpu_wr_cond = ~cpu_asn & ~cpu_dsn[0] & ~cpu_rnw & none & ~&cpu_fc;

// the mcu takes the port, the cpu is locked out once the mcu has written
always_comb begin
    if (mcu_wr) begin
        wr_en  = 1'b1;
        wr_idx = mcu_addr;
        wr_dat = mcu_dout;
    end else begin
        wr_en  = cpu_wr_cond & ~cpu_wr_last & ~mcu_owns;
        wr_idx = cpu_addr;
        wr_dat = cpu_dout;
    end
end

assign x.op      = xfer_op_t'(wr_dat[1:0]);
assign x.start   = wr_en && wr_idx == reg_ctrl && !x.busy &&
                   (x.op == op_write || x.op == op_read);
assign x.rd_addr = {regs[reg_rdaddr][6:0], regs[reg_rdaddr+1], regs[reg_rdaddr+2]};
assign x.wr_addr = {regs[reg_wraddr][6:0], regs[reg_wraddr+1], regs[reg_wraddr+2]};
assign x.wr_data = {regs[reg_data_hi], regs[reg_data_lo]};

assign sndmap_dout = regs[reg_snd];

always_ff @(posedge clk) begin
    if (rst) begin
        for (int i = 0; i < 32; i++) begin
            regs[i] <= 8'd0;
        end
        regs[reg_ipl] <= 8'd7;
        mcu_owns      <= 1'b0;
        cpu_wr_last   <= 1'b0;
        rd_pend       <= 1'b0;
        sndmap_pbf    <= 1'b0;
        snd_intn      <= 1'b1;
    end else begin
        cpu_wr_last <= cpu_wr_cond;
        if (mcu_wr) mcu_owns <= 1'b1;  // stays until reset
        if (x.done) begin
            rd_pend <= 1'b0;
            if (rd_pend) {regs[reg_data_hi], regs[reg_data_lo]} <= x.rd_data;
        end
        if (x.start) rd_pend <= x.op == op_read;
        if (wr_en) begin
            regs[wr_idx] <= wr_dat;
            if (wr_idx == reg_snd) sndmap_pbf <= 1'b1;
        end
        if (sndmap_rd) sndmap_pbf <= 1'b0;
        if (inta) regs[reg_ipl][2:0] <= 3'b111;
        // there is no mcu read strobe, presenting address 3 reads the latch
        if (mcu_addr[1:0] == 2'd3 && !mcu_wr) snd_intn <= 1'b1;
        if (sndmap_wr) snd_intn <= 1'b0;
    end
end

always_ff @(posedge clk) begin
    if (sndmap_wr) snd_latch <= sndmap_din;
end

// mcu read port, one cycle behind the address
always_ff @(posedge clk) begin
    case (mcu_addr[1:0])
        2'd0: mcu_din <= regs[reg_data_hi];
        2'd1: mcu_din <= regs[reg_data_lo];
        2'd2: mcu_din <= {1'b0, x.busy, sndmap_pbf, 2'b00, 1'b1,
                          ~regs[reg_sys][1], ~regs[reg_sys][0]};
        default: mcu_din <= snd_latch;
    endcase
end

endmodule

`default_nettype wire

// ==== logic/region_decode.sv ====
`timescale 1ns/100ps
`default_nettype none

module region_decode import mapper_pkg::*; (
    input  logic [23:1]            addr,
    input  logic [2:0]             fc,
    input  logic [7:0]             regs [0:31],
    output logic [num_regions-1:0] active,
    output logic                   none,
    output logic [1:0]             dtack_code
);

logic [num_regions-1:0] hit;

// compare width follows the size code: 64k, 128k, 512k, 2M
function automatic logic region_match(input logic [7:0] size, input logic [7:0] base,
                                      input logic [23:1] a);
    case (size[1:0])
        2'd0:    return a[23:16] == base;
        2'd1:    return a[23:17] == base[7:1];
        2'd2:    return a[23:19] == base[7:3];
        default: return a[23:21] == base[7:5];
    endcase
endfunction

for (genvar i = 0; i < num_regions; i++) begin : g_hit
    assign hit[i] = region_match(regs[reg_region + 2*i], regs[reg_region + 2*i + 1], addr);
end

always_comb begin
    active     = '0;
    dtack_code = 2'd0;
    // walk down so the lowest matching region is the last one kept
    for (int i = num_regions - 1; i >= 0; i--) begin
        if (hit[i]) begin
            active     = '0;
            active[i]  = 1'b1;
            dtack_code = regs[reg_region + 2*i][3:2];
        end
    end
    none = ~|hit;
    if (&fc) begin  // interrupt acknowledge
        active     = '0;
        none       = 1'b0;
        dtack_code = 2'd0;
    end
end

endmodule

`default_nettype wire

// ==== logic/dtack_gen.sv ====
`timescale 1ns/100ps
`default_nettype none

module dtack_gen (
    input  logic       clk,
    input  logic       rst,
    input  logic       asn,
    input  logic [1:0] dtack_code,
    output logic       dtackn
);

logic [2:0] chain;  // chain[n] falls n+1 cycles after asn

always_ff @(posedge clk) begin
    if (rst || asn) begin
        chain <= 3'b111;
    end else begin
        chain <= {chain[1:0], 1'b0};
    end
end

// code 3 would use the external pin, here it behaves as code 0
always_comb begin
    case (dtack_code)
        2'd1:    dtackn = chain[1];
        2'd2:    dtackn = chain[2];
        default: dtackn = chain[0];
    endcase
end

endmodule

`default_nettype wire

// ==== logic/bus_xfer.sv ====
`timescale 1ns/100ps
`default_nettype none

module bus_xfer import mapper_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        bus_grant,
    input  logic [15:0] bus_dout,
    output logic        bus_rq,
    output logic        bus_mcu,
    output logic        bus_asn,
    output logic        xfer_rnw,
    output logic [23:1] xfer_addr,
    output logic [15:0] xfer_data,
    xfer_if.engine      x
);

localparam logic [2:0] last_beat = 3'd6;  // asn low for seven cycles

xfer_state_t state;
xfer_op_t    op_q;
logic [2:0]  wait_cnt;
logic        end_beat;

assign end_beat = state == st_access && wait_cnt == last_beat;
assign bus_rq   = state != st_idle;
assign bus_mcu  = state == st_access;
assign bus_asn  = state != st_access;
assign xfer_rnw = op_q == op_read;
assign x.busy   = bus_rq;

always_ff @(posedge clk) begin
    if (rst) begin
        state    <= st_idle;
        op_q     <= op_none;
        wait_cnt <= 3'd0;
        x.done   <= 1'b0;
    end else begin
        x.done <= end_beat;
        case (state)
            st_idle: begin
                if (x.start) begin
                    state <= st_request;
                    op_q  <= x.op;
                end
            end
            st_request: begin
                if (bus_grant) begin
                    state    <= st_access;
                    wait_cnt <= 3'd0;
                end
            end
            st_access: begin
                wait_cnt <= wait_cnt + 3'd1;
                if (end_beat) state <= st_idle;
            end
            default: state <= st_idle;
        endcase
    end
end

always_ff @(posedge clk) begin
    if (state == st_idle && x.start) begin
        xfer_addr <= x.op == op_read ? x.rd_addr : x.wr_addr;
        xfer_data <= x.wr_data;
    end
    if (end_beat) x.rd_data <= bus_dout;  // sampled as asn goes back high
end

endmodule

`default_nettype wire

// ==== logic/irq_ctrl.sv ====
`timescale 1ns/100ps
`default_nettype none

module irq_ctrl #(
    parameter int mcu_int_len = 512
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       vint,
    input  logic       pxl_cen,
    input  logic [2:0] cpu_fc,
    input  logic       cpu_asn,
    input  logic       mcu_owns,
    input  logic [2:0] ipl_reg,
    output logic [2:0] cpu_ipln,
    output logic       cpu_vpan,
    output logic       inta,
    output logic       vint_intn
);

localparam int cnt_w = $clog2(mcu_int_len + 1);

logic             last_vint;
logic             pend;
logic [cnt_w-1:0] cnt;  // pixel pulses left on the mcu interrupt
logic             vint_rise;

assign vint_rise = vint & ~last_vint;
assign inta      = &cpu_fc & ~cpu_asn;
assign cpu_vpan  = ~inta;  // autovector
assign vint_intn = cnt == '0;
assign cpu_ipln  = mcu_owns ? ipl_reg : (pend ? 3'b011 : 3'b111);

always_ff @(posedge clk) begin
    if (rst) begin
        last_vint <= 1'b0;
        pend      <= 1'b0;
        cnt       <= '0;
    end else begin
        last_vint <= vint;
        if (inta) begin
            pend <= 1'b0;
        end else if (vint_rise) begin
            pend <= 1'b1;
        end
        if (vint_rise) begin
            cnt <= cnt_w'(mcu_int_len);
        end else if (cnt != '0 && pxl_cen) begin
            cnt <= cnt - 1'b1;
        end
    end
end

endmodule

`default_nettype wire

// ==== logic/mapper_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module mapper_top import mapper_pkg::*; #(
    parameter int mcu_int_len = 512
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        pxl_cen,
    input  logic        vint,
    // 68000
    input  logic [23:1] cpu_addr,
    input  logic [15:0] cpu_dout,
    input  logic [1:0]  cpu_dsn,
    input  logic        cpu_asn,
    input  logic        cpu_rnw,
    input  logic [2:0]  cpu_fc,
    output logic        cpu_dtackn,
    output logic [2:0]  cpu_ipln,
    output logic        cpu_vpan,
    output logic        cpu_rst,
    output logic        cpu_haltn,
    // system bus
    output logic [23:1] addr_out,
    output logic [15:0] bus_din,
    input  logic [15:0] bus_dout,
    output logic        bus_asn,
    output logic        bus_rnw,
    output logic [1:0]  bus_dsn,
    output logic        bus_rq,
    input  logic        bus_grant,
    output logic        bus_mcu,
    output logic [7:0]  active,
    output logic        none,
    output logic [15:0] mapper_dout,
    // sound cpu
    input  logic        sndmap_rd,
    input  logic        sndmap_wr,
    input  logic [7:0]  sndmap_din,
    output logic [7:0]  sndmap_dout,
    output logic        sndmap_pbf,
    // mcu
    input  logic [4:0]  mcu_addr,
    input  logic [7:0]  mcu_dout,
    input  logic        mcu_wr,
    output logic [7:0]  mcu_din,
    output logic [1:0]  mcu_intn
);

logic [7:0]  regs [0:31];
logic        mcu_owns;
logic        inta;
logic        snd_intn;
logic        vint_intn;
logic [1:0]  dtack_code;
logic        xfer_asn;
logic        xfer_rnw;
logic [23:1] xfer_addr;
logic [15:0] xfer_data;
logic        rst_aux;

xfer_if xbus ();

// the transfer engine owns the bus while bus_mcu is high
assign addr_out    = bus_mcu ? xfer_addr : cpu_addr;
assign bus_din     = bus_mcu ? xfer_data : cpu_dout;
assign bus_asn     = bus_mcu ? xfer_asn  : cpu_asn;
assign bus_rnw     = bus_mcu ? xfer_rnw  : cpu_rnw;
assign bus_dsn     = bus_mcu ? 2'b00     : cpu_dsn;  // word access
assign mapper_dout = {regs[reg_dout_hi], regs[reg_dout_lo]};
assign cpu_haltn   = ~regs[reg_sys][1];
assign mcu_intn    = {snd_intn, vint_intn};

// cpu reset lags the request by two clocks
always_ff @(posedge clk) begin
    {cpu_rst, rst_aux} <= {rst_aux, rst | regs[reg_sys][0]};
end

mapper_regs u_regs (
    .clk         (clk),
    .rst         (rst),
    .cpu_addr    (cpu_addr[5:1]),
    .cpu_dout    (cpu_dout[7:0]),
    .cpu_asn     (cpu_asn),
    .cpu_dsn     (cpu_dsn),
    .cpu_rnw     (cpu_rnw),
    .none        (none),
    .cpu_fc      (cpu_fc),
    .mcu_addr    (mcu_addr),
    .mcu_dout    (mcu_dout),
    .mcu_wr      (mcu_wr),
    .mcu_din     (mcu_din),
    .sndmap_wr   (sndmap_wr),
    .sndmap_din  (sndmap_din),
    .sndmap_rd   (sndmap_rd),
    .sndmap_dout (sndmap_dout),
    .sndmap_pbf  (sndmap_pbf),
    .snd_intn    (snd_intn),
    .inta        (inta),
    .regs        (regs),
    .mcu_owns    (mcu_owns),
    .x           (xbus.regs)
);

region_decode u_decode (
    .addr       (addr_out),
    .fc         (cpu_fc),
    .regs       (regs),
    .active     (active),
    .none       (none),
    .dtack_code (dtack_code)
);

dtack_gen u_dtack (
    .clk        (clk),
    .rst        (rst),
    .asn        (cpu_asn),
    .dtack_code (dtack_code),
    .dtackn     (cpu_dtackn)
);

bus_xfer u_xfer (
    .clk       (clk),
    .rst       (rst),
    .bus_grant (bus_grant),
    .bus_dout  (bus_dout),
    .bus_rq    (bus_rq),
    .bus_mcu   (bus_mcu),
    .bus_asn   (xfer_asn),
    .xfer_rnw  (xfer_rnw),
    .xfer_addr (xfer_addr),
    .xfer_data (xfer_data),
    .x         (xbus.engine)
);

irq_ctrl #(
    .mcu_int_len (mcu_int_len)
) u_irq (
    .clk       (clk),
    .rst       (rst),
    .vint      (vint),
    .pxl_cen   (pxl_cen),
    .cpu_fc    (cpu_fc),
    .cpu_asn   (cpu_asn),
    .mcu_owns  (mcu_owns),
    .ipl_reg   (regs[reg_ipl][2:0]),
    .cpu_ipln  (cpu_ipln),
    .cpu_vpan  (cpu_vpan),
    .inta      (inta),
    .vint_intn (vint_intn)
);

endmodule

`default_nettype wire

// ==== tests/mapper_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module mapper_tb;

logic        clk;
logic        rst;
logic        pxl_cen;
logic        vint;
logic [23:1] cpu_addr;
logic [15:0] cpu_dout;
logic [1:0]  cpu_dsn;
logic        cpu_asn;
logic        cpu_rnw;
logic [2:0]  cpu_fc;
logic        cpu_dtackn;
logic [2:0]  cpu_ipln;
logic        cpu_vpan;
logic        cpu_rst;
logic        cpu_haltn;
logic [23:1] addr_out;
logic [15:0] bus_din;
logic [15:0] bus_dout;
logic        bus_asn;
logic        bus_rnw;
logic [1:0]  bus_dsn;
logic        bus_rq;
logic        bus_grant;
logic        bus_mcu;
logic [7:0]  active;
logic        none;
logic [15:0] mapper_dout;
logic        sndmap_rd;
logic        sndmap_wr;
logic [7:0]  sndmap_din;
logic [7:0]  sndmap_dout;
logic        sndmap_pbf;
logic [4:0]  mcu_addr;
logic [7:0]  mcu_dout;
logic        mcu_wr;
logic [7:0]  mcu_din;
logic [1:0]  mcu_intn;

logic [31:0] lfsr = 32'h91140535;
int          cycles = 0;
logic [7:0]  sizes [0:7];  // copy of what the mcu programmed
logic [7:0]  bases [0:7];

mapper_top #(.mcu_int_len(16)) u_mapper_top (.*);

initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
end

always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles > 4000) begin
        $display("timeout, the tests did not finish within 4000 cycles");
        $display("Finished with errors");
        $fatal(1);
    end
end

always @(posedge clk) pxl_cen <= ~pxl_cen;  // pixel enable every other clock

// galois lfsr, one step per bit taken
function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
        v    = {v[30:0], lfsr[0]};
        lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'hD0000001) : (lfsr >> 1);
    end
    return v;
endfunction

// lowest region whose base matches at its size width, -1 for no match
function automatic int ref_region(input logic [23:1] a);
    int sh;
    for (int i = 0; i < 8; i++) begin
        case (sizes[i][1:0])
            2'd0:    sh = 0;
            2'd1:    sh = 1;
            2'd2:    sh = 3;
            default: sh = 5;
        endcase
        if ((a[23:16] >> sh) == (bases[i] >> sh)) return i;
    end
    return -1;
endfunction

task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
        $display("CHECK FAILED at %0t: %s is %0h, expected %0h", $time, name, got, exp);
        $display("Finished with errors");
        $fatal(1);
    end
endtask

task automatic mcu_write(input logic [4:0] idx, input logic [7:0] data);
    @(posedge clk);
    mcu_addr <= idx;
    mcu_dout <= data;
    mcu_wr   <= 1'b1;
    @(posedge clk);
    mcu_wr   <= 1'b0;
    mcu_addr <= 5'd0;
endtask

task automatic mcu_read(input logic [4:0] idx, output logic [7:0] data);
    @(posedge clk);
    mcu_addr <= idx;
    @(posedge clk);
    @(negedge clk);
    data = mcu_din;
    @(posedge clk);
    mcu_addr <= 5'd0;  // park away from the latch address
endtask

task automatic cpu_write(input logic [4:0] idx, input logic [7:0] data);
    @(posedge clk);
    cpu_addr <= {18'h3FFFF, idx};  // above every reset region, so none is high
    cpu_dout <= {8'h00, data};
    cpu_fc   <= 3'b101;
    cpu_asn  <= 1'b0;
    cpu_dsn  <= 2'b00;
    cpu_rnw  <= 1'b0;
    repeat (2) @(posedge clk);
    cpu_asn  <= 1'b1;
    cpu_dsn  <= 2'b11;
    cpu_rnw  <= 1'b1;
endtask

initial begin
    logic [7:0]  rd;
    logic [7:0]  val;
    logic [15:0] word;
    logic [23:1] a;
    int          hit;
    int          n;
    int          exp_n;

    rst = 1'b1;
    pxl_cen = 1'b0;
    vint = 1'b0;
    cpu_addr = '0;
    cpu_dout = '0;
    cpu_dsn = 2'b11;
    cpu_asn = 1'b1;
    cpu_rnw = 1'b1;
    cpu_fc = 3'b101;
    bus_dout = '0;
    bus_grant = 1'b0;
    sndmap_rd = 1'b0;
    sndmap_wr = 1'b0;
    sndmap_din = '0;
    mcu_addr = '0;
    mcu_dout = '0;
    mcu_wr = 1'b0;
    repeat (3) @(posedge clk);
    rst <= 1'b0;
    repeat (3) @(posedge clk);
    @(negedge clk);

    // idle outputs after reset
    check("bus_rq", bus_rq, 0);
    check("bus_mcu", bus_mcu, 0);
    check("bus_asn", bus_asn, 1);
    check("cpu_dtackn", cpu_dtackn, 1);
    check("cpu_vpan", cpu_vpan, 1);
    check("mcu_intn", mcu_intn, 2'b11);
    check("cpu_ipln", cpu_ipln, 3'b111);
    check("sndmap_pbf", sndmap_pbf, 0);
    check("cpu_rst", cpu_rst, 0);
    cpu_write(5'd4, 8'h05);
    cpu_write(5'd2, 8'h03);  // halt and hold in reset
    mcu_read(5'd2, rd);
    check("mcu_din status", rd, 8'h04);
    check("cpu_haltn", cpu_haltn, 0);
    check("cpu_rst", cpu_rst, 1);
    cpu_write(5'd2, 8'h00);

    // vblank interrupt before the mcu owns the registers
    @(posedge clk);
    vint <= 1'b1;
    @(negedge clk);
    while (mcu_intn[0] !== 1'b0) @(negedge clk);
    check("cpu_ipln", cpu_ipln, 3'b011);
    n = 0;
    while (mcu_intn[0] === 1'b0) begin
        if (pxl_cen) n++;
        @(negedge clk);
    end
    check("mcu_intn[0] pulse count", n, 16);
    check("cpu_ipln", cpu_ipln, 3'b011);
    @(posedge clk);
    vint    <= 1'b0;
    cpu_fc  <= 3'b111;
    cpu_asn <= 1'b0;
    @(negedge clk);
    check("cpu_vpan", cpu_vpan, 0);
    @(negedge clk);
    check("cpu_ipln", cpu_ipln, 3'b111);
    @(posedge clk);
    cpu_asn <= 1'b1;
    cpu_fc  <= 3'b101;

    // sound latch
    val = 8'(rand_bits(8));
    @(posedge clk);
    sndmap_wr  <= 1'b1;
    sndmap_din <= val;
    @(posedge clk);
    sndmap_wr  <= 1'b0;
    @(negedge clk);
    check("mcu_intn[1]", mcu_intn[1], 0);
    mcu_read(5'd3, rd);
    check("mcu_din latch", rd, val);
    check("mcu_intn[1]", mcu_intn[1], 1);
    val = 8'(rand_bits(8));
    cpu_write(5'd3, val);
    @(negedge clk);
    check("sndmap_pbf", sndmap_pbf, 1);
    check("sndmap_dout", sndmap_dout, val);
    @(posedge clk);
    sndmap_rd <= 1'b1;
    @(posedge clk);
    sndmap_rd <= 1'b0;
    @(negedge clk);
    check("sndmap_pbf", sndmap_pbf, 0);

    // mcu programs the regions, from here on the cpu is locked out
    for (int i = 0; i < 8; i++) begin
        sizes[i] = 8'(rand_bits(8));
        bases[i] = 8'(rand_bits(8));
        mcu_write(5'(16 + 2*i), sizes[i]);
        mcu_write(5'(17 + 2*i), bases[i]);
    end

    for (int t = 0; t < 16; t++) begin
        a = 23'(rand_bits(23));
        if (rand_bits(1)) a[23:16] = bases[rand_bits(3)];  // aim at a region
        hit = ref_region(a);
        @(posedge clk);
        cpu_addr <= a;
        cpu_fc   <= 3'b101;
        @(negedge clk);
        check("active", active, hit < 0 ? 8'h00 : 8'h01 << hit);
        check("none", none, hit < 0);
        if (hit < 0 || sizes[hit][3:2] == 2'd3) exp_n = 1;
        else exp_n = sizes[hit][3:2] + 1;
        @(posedge clk);
        cpu_asn <= 1'b0;
        n = 0;
        do begin
            @(posedge clk);
            n++;
            @(negedge clk);
        end while (cpu_dtackn === 1'b1 && n < 8);
        check("dtack delay", n, exp_n);
        @(posedge clk);
        cpu_asn <= 1'b1;
        @(negedge clk);
        check("cpu_dtackn", cpu_dtackn, 0);
        @(negedge clk);
        check("cpu_dtackn", cpu_dtackn, 1);
        @(posedge clk);
        cpu_fc <= 3'b111;
        @(negedge clk);
        check("active in acknowledge", active, 8'h00);
        check("none in acknowledge", none, 0);
    end
    @(posedge clk);
    cpu_fc <= 3'b101;

    // write transfer
    word = 16'(rand_bits(16));
    a    = 23'(rand_bits(23));
    mcu_write(5'd0, word[15:8]);
    mcu_write(5'd1, word[7:0]);
    mcu_write(5'd10, {1'b0, a[23:17]});
    mcu_write(5'd11, a[16:9]);
    mcu_write(5'd12, a[8:1]);
    mcu_write(5'd5, 8'h01);
    @(negedge clk);
    check("bus_rq", bus_rq, 1);
    check("bus_mcu", bus_mcu, 0);
    @(posedge clk);
    bus_grant <= 1'b1;
    while (bus_mcu !== 1'b1) @(negedge clk);
    n = 0;
    while (bus_asn === 1'b0) begin
        check("addr_out", addr_out, a);
        check("bus_din", bus_din, word);
        check("bus_rnw", bus_rnw, 0);
        check("bus_dsn", bus_dsn, 2'b00);
        n++;
        @(negedge clk);
    end
    check("bus_asn low cycles", n, 7);
    check("bus_rq", bus_rq, 0);
    @(posedge clk);
    bus_grant <= 1'b0;

    // read transfer
    a = 23'(rand_bits(23));
    mcu_write(5'd7, {1'b0, a[23:17]});
    mcu_write(5'd8, a[16:9]);
    mcu_write(5'd9, a[8:1]);
    word = 16'(rand_bits(16));
    @(posedge clk);
    bus_dout  <= word;
    bus_grant <= 1'b1;
    mcu_write(5'd5, 8'h02);
    @(negedge clk);
    while (bus_mcu !== 1'b1) @(negedge clk);
    check("addr_out", addr_out, a);
    check("bus_rnw", bus_rnw, 1);
    while (bus_asn === 1'b0) @(negedge clk);
    @(posedge clk);
    bus_grant <= 1'b0;
    mcu_read(5'd0, rd);
    check("read data high", rd, word[15:8]);
    mcu_read(5'd1, rd);
    check("read data low", rd, word[7:0]);

    // mcu sets the interrupt level directly
    val = 8'(rand_bits(8));
    if (val[2:0] == 3'b111) val[2] = 1'b0;  // 111 looks the same as no override
    mcu_write(5'd4, val);
    @(negedge clk);
    check("cpu_ipln", cpu_ipln, val[2:0]);

    // mapper data out registers
    word = 16'(rand_bits(16));
    mcu_write(5'd13, word[15:8]);
    mcu_write(5'd14, word[7:0]);
    @(negedge clk);
    check("mapper_dout", mapper_dout, word);

    $display("Finished with no errors");
    $finish;
end

endmodule

`default_nettype wire

// ==== vlog.f ====
logic/mapper_pkg.sv
logic/xfer_if.sv
logic/mapper_regs.sv
logic/region_decode.sv
logic/dtack_gen.sv
logic/bus_xfer.sv
logic/irq_ctrl.sv
logic/mapper_top.sv
tests/mapper_tb.sv

// ==== Makefile ====
SIM = obj_dir/mapper_sim

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module mapper_tb -f vlog.f

$(SIM): vlog.f logic/*.sv tests/*.sv
	verilator --binary --timing --top-module mapper_tb -o mapper_sim -f vlog.f

sim: $(SIM)
	-./$(SIM) > sim.log 2>&1
	cat sim.log
	grep -q "Finished with no errors" sim.log

clean:
	rm -rf obj_dir sim.log
